/* common/thiele_pkg.sv */
package thiele_pkg;

    // ========================================================================
    // Field widths
    // ========================================================================

    localparam int WORD_W    = 32;
    localparam int OPCODE_W  = 8;
    localparam int OPERAND_W = 8;

    // Instruction layout: opcode, operand A, operand B, spare byte
    localparam int OPC_LSB   = 24;
    localparam int OPA_LSB   = 16;
    localparam int OPB_LSB   = 8;

    // Parity bit of the XOR_LOAD row data in operand B
    localparam int PARITY_BIT = 7;

    typedef logic [WORD_W-1:0] word_t;

    // ========================================================================
    // Opcodes and internal commands
    // ========================================================================

    typedef enum logic [OPCODE_W-1:0] {
        OP_LASSERT  = 8'h03,
        OP_LJOIN    = 8'h04,
        OP_XOR_LOAD = 8'h0A,
        OP_XOR_ADD  = 8'h0B,
        OP_XOR_SWAP = 8'h0C,
        OP_XOR_RANK = 8'h0D,
        OP_EMIT     = 8'h0E
    } opcode_e;

    // Matrix engine command, XC_NONE also for rejected instructions
    typedef enum logic [2:0] {
        XC_NONE,
        XC_LOAD,
        XC_ADD,
        XC_SWAP,
        XC_RANK
    } xor_cmd_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_LOGIC
    } seq_state_e;

    // ========================================================================
    // Status and error codes
    // ========================================================================

    localparam word_t STATUS_JOIN  = 32'h0000_0004;
    localparam word_t STATUS_LOAD  = 32'h0000_0007;
    localparam word_t STATUS_ADD   = 32'h0000_0008;
    localparam word_t STATUS_SWAP  = 32'h0000_0009;

    localparam word_t ERR_NONE     = 32'h0000_0000;
    localparam word_t ERR_OPCODE   = 32'h0000_0001;
    localparam word_t ERR_ADD_ROW  = 32'h0000_000A;
    localparam word_t ERR_SWAP_ROW = 32'h0000_000B;
    localparam word_t ERR_LOAD_ROW = 32'h0000_000C;

    // Byte-addressed instruction stream
    localparam word_t PC_STEP = 32'd4;

endpackage

/* design/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode import thiele_pkg::*; #(
    parameter int XOR_ROWS = 4,
    parameter int XOR_COLS = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_instr,
    input  word_t                instr_data,
    output opcode_e              op,
    output xor_cmd_e             xor_cmd,
    output word_t                err_code,
    output logic [OPERAND_W-1:0] operand_a,
    output logic [OPERAND_W-1:0] operand_b
);

    // Row data plus parity must fit in operand B, rows must fit in operand A
    if (XOR_COLS > PARITY_BIT || XOR_ROWS > (1 << OPERAND_W)) begin : g_size_check
        $error("instr_decode: matrix size does not fit the operand fields");
    end

    // Raw fields of the incoming word
    opcode_e              opc_in;
    logic [OPERAND_W-1:0] a_in;
    logic [OPERAND_W-1:0] b_in;
    xor_cmd_e             cmd_in;
    word_t                err_in;

    assign opc_in = opcode_e'(instr_data[OPC_LSB +: OPCODE_W]);
    assign a_in   = instr_data[OPA_LSB +: OPERAND_W];
    assign b_in   = instr_data[OPB_LSB +: OPERAND_W];

    // Classification, row range checks live only here
    always_comb begin
        cmd_in = XC_NONE;
        err_in = ERR_NONE;
        case (opc_in)
            OP_XOR_LOAD: begin
                if (a_in < XOR_ROWS) cmd_in = XC_LOAD;
                else                 err_in = ERR_LOAD_ROW;
            end
            OP_XOR_ADD: begin
                if (a_in < XOR_ROWS && b_in < XOR_ROWS) cmd_in = XC_ADD;
                else                                    err_in = ERR_ADD_ROW;
            end
            OP_XOR_SWAP: begin
                if (a_in < XOR_ROWS && b_in < XOR_ROWS) cmd_in = XC_SWAP;
                else                                    err_in = ERR_SWAP_ROW;
            end
            OP_XOR_RANK: cmd_in = XC_RANK;
            // No matrix work for the logic and emit group
            OP_LASSERT, OP_LJOIN, OP_EMIT: ;
            default:     err_in = ERR_OPCODE;
        endcase
    end

    // Held from the end of DECODE until the next load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op        <= OP_LJOIN;
            xor_cmd   <= XC_NONE;
            err_code  <= ERR_NONE;
            operand_a <= '0;
            operand_b <= '0;
        end else if (load_instr) begin
            op        <= opc_in;
            xor_cmd   <= cmd_in;
            err_code  <= err_in;
            operand_a <= a_in;
            operand_b <= b_in;
        end
    end

    // Rejected instruction never reaches the matrix
    a_err_no_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (err_code != ERR_NONE) |-> (xor_cmd == XC_NONE));

endmodule

/* xor_matrix/xor_matrix_unit.sv */
`timescale 1ns/1ns

module xor_matrix_unit import thiele_pkg::*; #(
    parameter int XOR_ROWS = 4,
    parameter int XOR_COLS = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 exec_en,
    input  xor_cmd_e             xor_cmd,
    input  logic [OPERAND_W-1:0] operand_a,
    input  logic [OPERAND_W-1:0] operand_b,
    output word_t                rank
);

    localparam int ROW_W = (XOR_ROWS > 1) ? $clog2(XOR_ROWS) : 1;

    // Power-on pattern for the 4 x 6 core, bit index is the column
    localparam int INIT_ROWS = 4;
    localparam int INIT_COLS = 6;
    localparam logic [INIT_ROWS-1:0][INIT_COLS-1:0] INIT_BITS = {
        6'b000011,
        6'b100100,
        6'b010010,
        6'b101001
    };
    localparam logic [INIT_ROWS-1:0] INIT_PAR = 4'b0110;

    // ========================================================================
    // Matrix storage
    // ========================================================================

    logic [XOR_COLS-1:0] row_q [XOR_ROWS];
    logic                par_q [XOR_ROWS];

    // Row indices, range already checked in decode
    logic [ROW_W-1:0] ra;
    logic [ROW_W-1:0] rb;

    assign ra = operand_a[ROW_W-1:0];
    assign rb = operand_b[ROW_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < XOR_ROWS; r++) begin
                for (int c = 0; c < XOR_COLS; c++) begin
                    // Rows or columns beyond the pattern start cleared
                    row_q[r][c] <= (r < INIT_ROWS && c < INIT_COLS) ? INIT_BITS[r][c] : 1'b0;
                end
                par_q[r] <= (r < INIT_ROWS) ? INIT_PAR[r] : 1'b0;
            end
        end else if (exec_en) begin
            case (xor_cmd)
                XC_LOAD: begin
                    row_q[ra] <= operand_b[XOR_COLS-1:0];
                    par_q[ra] <= operand_b[PARITY_BIT];
                end
                // Target row A gets source row B added over GF(2)
                XC_ADD: begin
                    row_q[ra] <= row_q[ra] ^ row_q[rb];
                    par_q[ra] <= par_q[ra] ^ par_q[rb];
                end
                // Nonblocking pair, parity travels with the row
                XC_SWAP: begin
                    row_q[ra] <= row_q[rb];
                    row_q[rb] <= row_q[ra];
                    par_q[ra] <= par_q[rb];
                    par_q[rb] <= par_q[ra];
                end
                default: ;
            endcase
        end
    end

    // ========================================================================
    // Rank
    // ========================================================================

    // Simplified rank, rows with a pivot in column 0
    always_comb begin
        rank = '0;
        for (int r = 0; r < XOR_ROWS; r++) begin
            if (row_q[r][0]) rank = rank + 1'b1;
        end
    end

    a_rank_bound: assert property (@(posedge clk) disable iff (!rst_n)
        rank <= XOR_ROWS);

endmodule

/* design/result_regs.sv */
`timescale 1ns/1ns

module result_regs import thiele_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 exec_en,
    input  opcode_e              op,
    input  word_t                err_code,
    input  logic [OPERAND_W-1:0] operand_a,
    input  logic [OPERAND_W-1:0] operand_b,
    input  word_t                rank,
    input  word_t                logic_dat,
    output word_t                cert_addr,
    output word_t                status,
    output word_t                error_code,
    output word_t                xor_ops,
    output word_t                info_gain
);

    // Operand pair in the upper half word
    word_t packed_ops;

    assign packed_ops = {operand_a, operand_b, 16'h0000};

    // ========================================================================
    // Architectural registers
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cert_addr  <= '0;
            status     <= '0;
            error_code <= '0;
            xor_ops    <= '0;
            info_gain  <= '0;
        end else if (exec_en) begin
            if (err_code != ERR_NONE) begin
                // Only the error register moves on a fault
                error_code <= err_code;
            end else begin
                case (op)
                    OP_XOR_LOAD: status <= STATUS_LOAD;
                    OP_XOR_ADD: begin
                        status  <= STATUS_ADD;
                        xor_ops <= xor_ops + 1'b1;
                    end
                    OP_XOR_SWAP: begin
                        status  <= STATUS_SWAP;
                        xor_ops <= xor_ops + 1'b1;
                    end
                    OP_XOR_RANK: status <= rank;
                    OP_LJOIN: begin
                        status    <= STATUS_JOIN;
                        cert_addr <= packed_ops;
                    end
                    OP_EMIT: begin
                        status <= packed_ops;
                        // A of zero seeds the counter with B
                        if (operand_a == '0) info_gain <= word_t'(operand_b);
                        else                 info_gain <= info_gain + 1'b1;
                    end
                    // Certificate comes back from the logic engine
                    OP_LASSERT: cert_addr <= logic_dat;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* design/cpu_sequencer.sv */
`timescale 1ns/1ns

module cpu_sequencer import thiele_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  opcode_e              op,
    input  logic                 logic_ack,
    input  logic [OPERAND_W-1:0] operand_a,
    input  logic [OPERAND_W-1:0] operand_b,
    output word_t                pc,
    output logic                 load_instr,
    output logic                 exec_en,
    output logic                 logic_cyc,
    output logic                 logic_stb,
    output word_t                logic_adr
);

    seq_state_e state;

    // ========================================================================
    // Sequencer FSM
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_FETCH;
            pc        <= '0;
            logic_cyc <= 1'b0;
            logic_stb <= 1'b0;
        end else begin
            case (state)
                // Instruction word settles on the combinational fetch
                ST_FETCH:  state <= ST_DECODE;
                ST_DECODE: state <= ST_EXECUTE;
                ST_EXECUTE: begin
                    if (op == OP_LASSERT) begin
                        // Open the bus cycle, cyc and stb together
                        state     <= ST_LOGIC;
                        logic_cyc <= 1'b1;
                        logic_stb <= 1'b1;
                    end else begin
                        state <= ST_FETCH;
                        pc    <= pc + PC_STEP;
                    end
                end
                ST_LOGIC: begin
                    // Wait without limit for the engine
                    if (logic_ack) begin
                        state     <= ST_FETCH;
                        pc        <= pc + PC_STEP;
                        logic_cyc <= 1'b0;
                        logic_stb <= 1'b0;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Capture strobe for the decode register
    assign load_instr = (state == ST_DECODE);

    // One pulse per instruction
    // LASSERT retires on the accepted ack, the rest in EXECUTE
    assign exec_en = ((state == ST_EXECUTE) && (op != OP_LASSERT)) ||
                     ((state == ST_LOGIC) && logic_ack);

    // Query address from the held operands
    assign logic_adr = {16'h0000, operand_a, operand_b};

    // ========================================================================
    // Bus protocol checks
    // ========================================================================

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        logic_stb |-> logic_cyc);

    // Cycle only closes after an accepted ack
    a_cyc_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(logic_cyc) |-> $past(logic_ack));

endmodule

/* design/thiele_core.sv */
`timescale 1ns/1ns

module thiele_core import thiele_pkg::*; #(
    parameter int XOR_ROWS = 4,
    parameter int XOR_COLS = 6
) (
    input  logic  clk,
    input  logic  rst_n,
    // Instruction fetch
    input  word_t instr_data,
    output word_t pc,
    // Logic engine, read-only Wishbone classic
    output logic  logic_cyc,
    output logic  logic_stb,
    output word_t logic_adr,
    input  logic  logic_ack,
    input  word_t logic_dat,
    // Result registers
    output word_t cert_addr,
    output word_t status,
    output word_t error_code,
    output word_t xor_ops,
    output word_t info_gain
);

    // Decode to execute wiring
    opcode_e              op;
    xor_cmd_e             xor_cmd;
    word_t                err_code;
    logic [OPERAND_W-1:0] operand_a;
    logic [OPERAND_W-1:0] operand_b;
    word_t                rank;
    logic                 load_instr;
    logic                 exec_en;

    instr_decode #(.XOR_ROWS(XOR_ROWS), .XOR_COLS(XOR_COLS)) u_decode (
        .clk, .rst_n, .load_instr, .instr_data,
        .op, .xor_cmd, .err_code, .operand_a, .operand_b
    );

    xor_matrix_unit #(.XOR_ROWS(XOR_ROWS), .XOR_COLS(XOR_COLS)) u_matrix (
        .clk, .rst_n, .exec_en, .xor_cmd, .operand_a, .operand_b, .rank
    );

    result_regs u_regs (
        .clk, .rst_n, .exec_en, .op, .err_code, .operand_a, .operand_b,
        .rank, .logic_dat, .cert_addr, .status, .error_code, .xor_ops, .info_gain
    );

    cpu_sequencer u_seq (
        .clk, .rst_n, .op, .logic_ack, .operand_a, .operand_b, .pc,
        .load_instr, .exec_en, .logic_cyc, .logic_stb, .logic_adr
    );

endmodule

/* bench/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker import thiele_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t pc,
    input  logic  logic_cyc,
    input  logic  logic_stb,
    input  word_t logic_adr,
    input  word_t cert_addr,
    input  word_t status,
    input  word_t error_code,
    input  word_t xor_ops,
    input  word_t info_gain,
    input  int    num_tests,
    input  int    ack_wait,
    input  word_t exp_instr,
    input  word_t exp_cert,
    input  word_t exp_status,
    input  word_t exp_err,
    input  word_t exp_ops,
    input  word_t exp_gain,
    input  logic  trace_bad,
    input  logic  wd_expired,
    output int    test_idx,
    output logic  done,
    output int    fail_count
);

    word_t last_pc;
    int    cycles;
    int    pass_count;
    logic  test_bad;

    initial begin
        test_idx   = 0;
        done       = 1'b0;
        fail_count = 0;
        pass_count = 0;
        last_pc    = '0;
        cycles     = 0;
        test_bad   = 1'b0;
    end

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    task automatic print_summary();
        $display("tests %0d, passed %0d, failed %0d", test_idx, pass_count, fail_count);
    endtask

    // ========================================================================
    // Retirement checks
    // ========================================================================

    // Cycles since the last retirement
    always @(posedge clk) begin
        if (rst_n) cycles = cycles + 1;
    end

    task automatic check_retired();
        int exp_cycles;
        // LASSERT spends one LOGIC cycle plus the ack wait
        exp_cycles = (exp_instr[31:24] == OP_LASSERT) ? 4 + ack_wait : 3;
        compare("pc", last_pc + PC_STEP, pc);
        compare("retire cycles", word_t'(exp_cycles), word_t'(cycles));
        compare("cert_addr", exp_cert, cert_addr);
        compare("status", exp_status, status);
        compare("error_code", exp_err, error_code);
        compare("xor_ops", exp_ops, xor_ops);
        compare("info_gain", exp_gain, info_gain);
        if (test_bad) begin
            fail_count++;
            $display("test %0d instr %h: FAIL", test_idx, exp_instr);
        end else begin
            pass_count++;
            $display("test %0d instr %h: ok", test_idx, exp_instr);
        end
        test_bad = 1'b0;
        cycles   = 0;
        last_pc  = pc;
        test_idx = test_idx + 1;
        if (test_idx >= num_tests) begin
            print_summary();
            done = 1'b1;
        end
    endtask

    // Outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (rst_n && !done && pc !== last_pc) check_retired();
    end

    // Bus cycle only for LASSERT, with strobe and query address
    always @(negedge clk) begin
        if (rst_n && logic_cyc) begin
            if (exp_instr[31:24] != OP_LASSERT) begin
                $display("at %0t ns a bus cycle is open for an instruction other than LASSERT",
                         $time);
                test_bad = 1'b1;
            end
            if (!logic_stb) begin
                $display("at %0t ns the bus cycle is open but logic_stb is low", $time);
                test_bad = 1'b1;
            end
            compare("logic_adr", {16'h0000, exp_instr[23:8]}, logic_adr);
        end
    end

    // ========================================================================
    // Run-level failures
    // ========================================================================

    always @(posedge trace_bad) begin
        $display("trace file could not be read, no tests were loaded");
    end

    always @(posedge wd_expired) begin
        $display("watchdog expired after %0d of %0d tests, the DUT stopped retiring",
                 test_idx, num_tests);
        print_summary();
    end

endmodule

/* bench/tb_thiele.sv */
`timescale 1ns/1ns

module tb_thiele import thiele_pkg::*; ();

    // Trace layout: instr, engine data, cert, status, error, xor_ops, info_gain
    localparam int    FIELDS     = 7;
    localparam int    MAX_TESTS  = 64;
    localparam string TRACE_FILE = "bench/thiele_trace.txt";

    logic  clk;
    logic  rst_n;
    word_t instr_data;
    word_t pc;
    logic  logic_cyc;
    logic  logic_stb;
    word_t logic_adr;
    logic  logic_ack;
    word_t logic_dat;
    word_t cert_addr;
    word_t status;
    word_t error_code;
    word_t xor_ops;
    word_t info_gain;

    // Trace storage, an all-zero instruction word ends the list
    word_t       trace_mem [FIELDS*MAX_TESTS];
    int          num_tests;
    int          test_idx;
    int          ack_wait;
    int          fail_count;
    logic        done;
    logic        trace_bad;
    logic        wd_expired;
    logic [15:0] lfsr;

    word_t exp_instr;
    word_t exp_cert;
    word_t exp_status;
    word_t exp_err;
    word_t exp_ops;
    word_t exp_gain;

    thiele_core #(.XOR_ROWS(4), .XOR_COLS(6)) dut (
        .clk, .rst_n, .instr_data, .pc,
        .logic_cyc, .logic_stb, .logic_adr, .logic_ack, .logic_dat,
        .cert_addr, .status, .error_code, .xor_ops, .info_gain
    );

    tb_checker u_checker (
        .clk, .rst_n, .pc, .logic_cyc, .logic_stb, .logic_adr,
        .cert_addr, .status, .error_code, .xor_ops, .info_gain,
        .num_tests, .ack_wait, .exp_instr, .exp_cert, .exp_status,
        .exp_err, .exp_ops, .exp_gain, .trace_bad, .wd_expired,
        .test_idx, .done, .fail_count
    );

    // Expected values of the instruction now in flight
    assign exp_instr  = trace_mem[FIELDS*test_idx + 0];
    assign exp_cert   = trace_mem[FIELDS*test_idx + 2];
    assign exp_status = trace_mem[FIELDS*test_idx + 3];
    assign exp_err    = trace_mem[FIELDS*test_idx + 4];
    assign exp_ops    = trace_mem[FIELDS*test_idx + 5];
    assign exp_gain   = trace_mem[FIELDS*test_idx + 6];

    always #5 clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_trace();
        for (int i = 0; i < FIELDS*MAX_TESTS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh(TRACE_FILE, trace_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && trace_mem[FIELDS*num_tests] != '0) begin
            num_tests++;
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Combinational fetch, refreshed on the falling edge
    always @(negedge clk) begin
        if (int'(pc >> 2) < num_tests) instr_data = trace_mem[FIELDS*int'(pc >> 2)];
        else                           instr_data = '0;
    end

    // Logic engine, random ack delay of 0 to 7 cycles
    initial begin : responder
        int delay;
        forever begin
            @(negedge clk);
            if (logic_cyc && logic_stb) begin
                draw_bits(3, delay);
                ack_wait = delay;
                repeat (delay) @(negedge clk);
                logic_ack = 1'b1;
                logic_dat = trace_mem[FIELDS*int'(pc >> 2) + 1];
                @(negedge clk);
                logic_ack = 1'b0;
                logic_dat = '0;
            end
        end
    end

    initial begin : main
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_data = '0;
        logic_ack  = 1'b0;
        logic_dat  = '0;
        trace_bad  = 1'b0;
        wd_expired = 1'b0;
        ack_wait   = 0;
        lfsr       = 16'(63121);
        load_trace();
        if (num_tests == 0) begin
            trace_bad = 1'b1;
            #1;
            $display("Checks failed");
            $finish;
        end else begin
            // Reset held for 3 cycles, released on a falling edge
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            wait (done);
            #1;
            if (fail_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Worst case per test is 3 cycles plus an ack wait below 8, doubled
    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = num_tests * (3 + 8) * 10 * 2;
        #(limit);
        wd_expired = 1'b1;
        #1;
        $display("Checks failed");
        $finish;
    end

endmodule

/* bench/thiele_trace.txt */
// instr    engine   cert     status   error    xor_ops  info_gain
// instr is opcode, A, B, spare byte; engine data is returned on the LASSERT ack
0D000000 00000000 00000000 00000002 00000000 00000000 00000000
0C000100 00000000 00000000 00000009 00000000 00000001 00000000
0B020300 00000000 00000000 00000008 00000000 00000002 00000000
0D000000 00000000 00000000 00000003 00000000 00000002 00000000
0B030100 00000000 00000000 00000008 00000000 00000003 00000000
0D000000 00000000 00000000 00000002 00000000 00000003 00000000
0A043F00 00000000 00000000 00000002 0000000C 00000003 00000000
0B050000 00000000 00000000 00000002 0000000A 00000003 00000000
0C010400 00000000 00000000 00000002 0000000B 00000003 00000000
0D000000 00000000 00000000 00000002 0000000B 00000003 00000000
0A008100 00000000 00000000 00000007 0000000B 00000003 00000000
0D000000 00000000 00000000 00000003 0000000B 00000003 00000000
0E000500 00000000 00000000 00050000 0000000B 00000003 00000005
0E021100 00000000 00000000 02110000 0000000B 00000003 00000006
04123400 00000000 12340000 00000004 0000000B 00000003 00000006
03567800 DEADBEEF DEADBEEF 00000004 0000000B 00000003 00000006
7F000000 00000000 DEADBEEF 00000004 00000001 00000003 00000006
03010200 0BADF00D 0BADF00D 00000004 00000001 00000003 00000006
0E010000 00000000 0BADF00D 01000000 00000001 00000003 00000007
0D000000 00000000 0BADF00D 00000003 00000001 00000003 00000007
03AABB00 12345678 12345678 00000003 00000001 00000003 00000007

/* project.f */
common/thiele_pkg.sv
design/instr_decode.sv
xor_matrix/xor_matrix_unit.sv
design/result_regs.sv
design/cpu_sequencer.sv
design/thiele_core.sv
bench/tb_checker.sv
bench/tb_thiele.sv

/* Bender.yml */
package:
  name: thiele_core

sources:
  - common/thiele_pkg.sv
  - design/instr_decode.sv
  - xor_matrix/xor_matrix_unit.sv
  - design/result_regs.sv
  - design/cpu_sequencer.sv
  - design/thiele_core.sv
  - target: test
    files:
      - bench/tb_checker.sv
      - bench/tb_thiele.sv
